// File: logic/fdiv_fsqrt_pkg.sv
/*
 * Divide and square-root unit shared definitions
 * Operation and rounding-mode encodings, exception flags and default operand format
 */
package fdiv_fsqrt_pkg;

  // ------------------------------------------------------------
  // Default operand format
  // ------------------------------------------------------------

  // Unsigned Q8.8 operands unless the top level says otherwise
  parameter int DS_WIDTH_GP = 16;
  parameter int DS_FRAC_GP  = 8;   // Kept even so the radicand splits into bit pairs

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  typedef enum logic {
    DS_OP_DIV  = 1'b0,  // Quotient a/b
    DS_OP_SQRT = 1'b1   // Root of a, b is ignored
  } ds_op_e;

  typedef enum logic [1:0] {
    DS_RM_RTZ = 2'd0,  // Truncate toward zero
    DS_RM_RUP = 2'd1,  // Toward plus infinity
    DS_RM_RNE = 2'd2   // Nearest, ties go to the even result
  } ds_rm_e;

  // Exception flags returned with every result
  typedef struct packed {
    logic dz;  // Division with a zero divisor
    logic of;  // Result saturated to all ones
    logic nx;  // Remainder was not zero
  } ds_flags_s;

endpackage

// File: logic/ds_if.sv
/*
 * Internal channels of the divide and square-root unit
 * Request from the issue stage to the iteration core, response from the core to writeback
 */
`timescale 1ns/1ps

// ------------------------------------------------------------
// Issue to core
// ------------------------------------------------------------
interface ds_req_if #(
  parameter int WIDTH_P = fdiv_fsqrt_pkg::DS_WIDTH_GP
) ();
  import fdiv_fsqrt_pkg::*;

  logic               start;  // One-cycle pulse per accepted request
  ds_op_e             op;
  ds_rm_e             rm;
  logic [WIDTH_P-1:0] a;
  logic [WIDTH_P-1:0] b;
  logic               dz;     // Divisor is zero on a division
  logic               busy;   // Core is working on the request

  modport source (output start, op, rm, a, b, dz, input busy);
  modport sink   (input start, op, rm, a, b, dz, output busy);

endinterface

// ------------------------------------------------------------
// Core to writeback
// ------------------------------------------------------------
interface ds_resp_if #(
  parameter int WIDTH_P = fdiv_fsqrt_pkg::DS_WIDTH_GP
) ();
  import fdiv_fsqrt_pkg::*;

  logic               done;    // One-cycle pulse with a finished result
  logic [WIDTH_P-1:0] result;
  ds_flags_s          flags;
  ds_op_e             op;
  logic               free;    // Writeback holds nothing

  modport source (output done, result, flags, op);
  modport sink   (input done, result, flags, op, output free);

endinterface

// File: logic/ds_issue.sv
/*
 * Divide and square-root issue stage
 * Accepts one request at a time, keeps its register tag and spots a zero divisor
 */
`timescale 1ns/1ps

module ds_issue #(
  parameter int WIDTH_P     = fdiv_fsqrt_pkg::DS_WIDTH_GP,
  parameter int TAG_WIDTH_P = 5
) (
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   v_i,
  input  logic [TAG_WIDTH_P-1:0] rd_i,
  input  fdiv_fsqrt_pkg::ds_op_e op_i,
  input  fdiv_fsqrt_pkg::ds_rm_e rm_i,
  input  logic [WIDTH_P-1:0]     a_i,
  input  logic [WIDTH_P-1:0]     b_i,
  output logic                   ready_o,

  output logic [TAG_WIDTH_P-1:0] tag_o,
  ds_req_if.source               req,
  input  logic                   wb_free_i
);
  import fdiv_fsqrt_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } issue_state_e;

  issue_state_e           state_r, state_n;
  logic                   accept;
  logic                   start_r;
  logic [TAG_WIDTH_P-1:0] tag_r;

  assign ready_o = (state_r == IDLE) & ~req.busy & wb_free_i;
  assign accept  = v_i & ready_o;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE: begin
        if (accept) begin
          state_n = BUSY;
        end
      end
      BUSY: begin
        // The request has left the core and the writeback was emptied by yumi
        if (!start_r && !req.busy && wb_free_i) begin
          state_n = IDLE;
        end
      end
      default: state_n = BUSY;
    endcase
  end

  // Reset parks the stage in BUSY so ready_o stays low until one cycle after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= BUSY;
      start_r <= 1'b0;
    end else begin
      state_r <= state_n;
      start_r <= accept;  // Core sees the operands one cycle after acceptance
    end
  end

  // ------------------------------------------------------------
  // Request payload
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_r  <= rd_i;
      req.op <= op_i;
      req.rm <= rm_i;
      req.a  <= a_i;
      req.b  <= b_i;
      req.dz <= (op_i == DS_OP_DIV) && (b_i == '0);
    end
  end

  assign req.start = start_r;
  assign tag_o     = tag_r;   // Held until the next acceptance

endmodule

// File: logic/ds_iter_core.sv
/*
 * Radix-2 restoring divide and square-root engine
 * One remainder datapath serves both operations, then a single cycle rounds and saturates
 */
`timescale 1ns/1ps

module ds_iter_core #(
  parameter int WIDTH_P = fdiv_fsqrt_pkg::DS_WIDTH_GP,
  parameter int FRAC_P  = fdiv_fsqrt_pkg::DS_FRAC_GP
) (
  input  logic       clk_i,
  input  logic       reset_i,
  ds_req_if.sink     req,
  ds_resp_if.source  resp
);
  import fdiv_fsqrt_pkg::*;

  localparam int N_LP     = WIDTH_P + FRAC_P;      // Bits of A = a * 2^FRAC_P
  localparam int REM_W_LP = WIDTH_P + 2;           // Room for the shifted remainder of either op
  localparam int CNT_W_LP = $clog2(N_LP + 1);

  typedef enum logic [1:0] {
    IDLE,
    ITER,
    ROUND
  } core_state_e;

  core_state_e         state_r;
  logic [CNT_W_LP-1:0] cnt_r;      // Iterations still to run
  logic                done_r;

  logic [N_LP-1:0]     acc_r;      // Dividend or radicand bits not yet consumed, MSB first
  logic [N_LP-1:0]     q_r;        // Partial quotient or root
  logic [REM_W_LP-1:0] rem_r;
  logic [WIDTH_P-1:0]  b_r;
  ds_op_e              op_r;
  ds_rm_e              rm_r;
  logic                dz_r;

  logic [WIDTH_P-1:0]  result_r;
  ds_flags_s           flags_r;

  // ------------------------------------------------------------
  // Shared iteration step
  // ------------------------------------------------------------
  logic                sqrt_op;
  logic [REM_W_LP-1:0] shifted;
  logic [REM_W_LP-1:0] subtrahend;
  logic [REM_W_LP:0]   diff;
  logic                ge;
  logic [REM_W_LP-1:0] rem_n;

  assign sqrt_op = (op_r == DS_OP_SQRT);

  always_comb begin
    if (sqrt_op) begin
      // Bring down two radicand bits and try 4*root + 1
      shifted    = {rem_r[REM_W_LP-3:0], acc_r[N_LP-1 -: 2]};
      subtrahend = {q_r[REM_W_LP-3:0], 2'b01};
    end else begin
      shifted    = {rem_r[REM_W_LP-2:0], acc_r[N_LP-1]};  // One dividend bit per step
      subtrahend = {2'b00, b_r};
    end
  end

  assign diff  = {1'b0, shifted} - {1'b0, subtrahend};
  assign ge    = ~diff[REM_W_LP];                       // No borrow means the trial fits
  assign rem_n = ge ? diff[REM_W_LP-1:0] : shifted;     // Restore on a failed trial

  // ------------------------------------------------------------
  // Rounding
  // ------------------------------------------------------------
  logic              rem_nz;
  logic [REM_W_LP:0] half_lhs;
  logic [REM_W_LP:0] half_rhs;
  logic              half_gt;
  logic              half_eq;
  logic              round_up;
  logic [N_LP:0]     q_rnd;
  logic              ovf;

  assign rem_nz = |rem_r;

  // Division compares 2r with b, square root compares r with s
  assign half_lhs = sqrt_op ? {1'b0, rem_r} : {rem_r, 1'b0};
  assign half_rhs = sqrt_op ? {1'b0, q_r[REM_W_LP-1:0]} : {3'b000, b_r};
  assign half_gt  = half_lhs > half_rhs;
  assign half_eq  = (half_lhs == half_rhs) & ~sqrt_op;  // r equal to s is still below half

  always_comb begin
    case (rm_r)
      DS_RM_RUP: round_up = rem_nz;
      DS_RM_RNE: round_up = half_gt | (half_eq & q_r[0]);
      default:   round_up = 1'b0;
    endcase
  end

  assign q_rnd = {1'b0, q_r} + {{N_LP{1'b0}}, round_up};
  assign ovf   = |q_rnd[N_LP:WIDTH_P];  // Quotient wider than the result format

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      cnt_r   <= '0;
      done_r  <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state_r)
        IDLE: begin
          if (req.start) begin
            state_r <= req.dz ? ROUND : ITER;  // Zero divisor skips the iterations
            cnt_r   <= (req.op == DS_OP_SQRT) ? CNT_W_LP'(N_LP / 2) : CNT_W_LP'(N_LP);
          end
        end
        ITER: begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == CNT_W_LP'(1)) begin
            state_r <= ROUND;
          end
        end
        ROUND: begin
          state_r <= IDLE;
          done_r  <= 1'b1;
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if ((state_r == IDLE) && req.start) begin
      op_r  <= req.op;
      rm_r  <= req.rm;
      dz_r  <= req.dz;
      b_r   <= req.b;
      acc_r <= N_LP'(req.a) << FRAC_P;
      q_r   <= '0;
      rem_r <= '0;
    end else if (state_r == ITER) begin
      acc_r <= sqrt_op ? (acc_r << 2) : (acc_r << 1);
      q_r   <= {q_r[N_LP-2:0], ge};
      rem_r <= rem_n;
    end

    if (state_r == ROUND) begin
      result_r   <= (dz_r | ovf) ? '1 : q_rnd[WIDTH_P-1:0];
      flags_r.dz <= dz_r;
      flags_r.of <= ~dz_r & ovf;
      flags_r.nx <= ~dz_r & rem_nz;
    end
  end

  assign req.busy    = (state_r != IDLE) | done_r;  // Covers the done cycle too
  assign resp.done   = done_r;
  assign resp.result = result_r;
  assign resp.flags  = flags_r;
  assign resp.op     = op_r;

endmodule

// File: logic/ds_writeback.sv
/*
 * Divide and square-root writeback
 * Holds one finished result with its tag until the consumer takes it with yumi
 */
`timescale 1ns/1ps

module ds_writeback #(
  parameter int WIDTH_P     = fdiv_fsqrt_pkg::DS_WIDTH_GP,
  parameter int TAG_WIDTH_P = 5
) (
  input  logic                      clk_i,
  input  logic                      reset_i,

  ds_resp_if.sink                   resp,
  input  logic [TAG_WIDTH_P-1:0]    tag_i,

  output logic                      v_o,
  output logic [WIDTH_P-1:0]        result_o,
  output fdiv_fsqrt_pkg::ds_flags_s flags_o,
  output logic [TAG_WIDTH_P-1:0]    rd_o,
  output fdiv_fsqrt_pkg::ds_op_e    op_o,
  input  logic                      yumi_i
);

  typedef enum logic {
    EMPTY,
    FULL
  } wb_state_e;

  wb_state_e state_r;

  // ------------------------------------------------------------
  // Hold state
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= EMPTY;
    end else begin
      case (state_r)
        EMPTY:   state_r <= resp.done ? FULL : EMPTY;
        FULL:    state_r <= yumi_i ? EMPTY : FULL;  // Released on the taking edge
        default: state_r <= EMPTY;
      endcase
    end
  end

  // Only one result is ever in flight, so done never arrives while FULL
  always_ff @(posedge clk_i) begin
    if ((state_r == EMPTY) && resp.done) begin
      result_o <= resp.result;
      flags_o  <= resp.flags;
      op_o     <= resp.op;
      rd_o     <= tag_i;
    end
  end

  assign v_o       = (state_r == FULL);
  assign resp.free = (state_r == EMPTY);

endmodule

// File: logic/fdiv_fsqrt_unit.sv
/*
 * Iterative fixed-point divide and square-root unit
 * Issue, iteration core and writeback in a valid/ready in, valid/yumi out pipe
 */
`timescale 1ns/1ps

module fdiv_fsqrt_unit #(
  parameter int WIDTH_P     = fdiv_fsqrt_pkg::DS_WIDTH_GP,
  parameter int FRAC_P      = fdiv_fsqrt_pkg::DS_FRAC_GP,   // Must be even
  parameter int TAG_WIDTH_P = 5
) (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      v_i,
  input  logic [TAG_WIDTH_P-1:0]    rd_i,
  input  fdiv_fsqrt_pkg::ds_op_e    op_i,
  input  fdiv_fsqrt_pkg::ds_rm_e    rm_i,
  input  logic [WIDTH_P-1:0]        a_i,
  input  logic [WIDTH_P-1:0]        b_i,
  output logic                      ready_o,

  output logic                      v_o,
  output logic [WIDTH_P-1:0]        result_o,
  output fdiv_fsqrt_pkg::ds_flags_s flags_o,
  output logic [TAG_WIDTH_P-1:0]    rd_o,
  output fdiv_fsqrt_pkg::ds_op_e    op_o,
  input  logic                      yumi_i
);

  logic [TAG_WIDTH_P-1:0] tag_lo;

  ds_req_if  #(.WIDTH_P(WIDTH_P)) req_if  ();
  ds_resp_if #(.WIDTH_P(WIDTH_P)) resp_if ();

  ds_issue #(
    .WIDTH_P     (WIDTH_P),
    .TAG_WIDTH_P (TAG_WIDTH_P)
  ) issue_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .v_i       (v_i),
    .rd_i      (rd_i),
    .op_i      (op_i),
    .rm_i      (rm_i),
    .a_i       (a_i),
    .b_i       (b_i),
    .ready_o   (ready_o),
    .tag_o     (tag_lo),
    .req       (req_if.source),
    .wb_free_i (resp_if.free)   // Next request waits until the result is taken
  );

  ds_iter_core #(
    .WIDTH_P (WIDTH_P),
    .FRAC_P  (FRAC_P)
  ) core_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req     (req_if.sink),
    .resp    (resp_if.source)
  );

  ds_writeback #(
    .WIDTH_P     (WIDTH_P),
    .TAG_WIDTH_P (TAG_WIDTH_P)
  ) wb_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .resp     (resp_if.sink),
    .tag_i    (tag_lo),
    .v_o      (v_o),
    .result_o (result_o),
    .flags_o  (flags_o),
    .rd_o     (rd_o),
    .op_o     (op_o),
    .yumi_i   (yumi_i)
  );

endmodule

// File: bench/fdiv_fsqrt_assert.sv
/*
 * Handshake checker for the divide and square-root unit, bound to its top level
 */
`timescale 1ns/1ps

module fdiv_fsqrt_assert #(
  parameter int WIDTH_P     = fdiv_fsqrt_pkg::DS_WIDTH_GP,
  parameter int TAG_WIDTH_P = 5
) (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      ready_o,
  input logic                      v_o,
  input logic [WIDTH_P-1:0]        result_o,
  input fdiv_fsqrt_pkg::ds_flags_s flags_o,
  input logic [TAG_WIDTH_P-1:0]    rd_o,
  input fdiv_fsqrt_pkg::ds_op_e    op_o,
  input logic                      yumi_i
);

  // A new request is never taken while a result waits
  ready_excludes_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ready_o && v_o)) else $error("ready_o and v_o high in the same cycle");

  // Back-pressure keeps the whole result in place
  hold_until_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(result_o) && $stable(flags_o)
                       && $stable(rd_o) && $stable(op_o))
    else $error("result changed or was dropped before yumi_i");

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o) else $error("yumi_i high without v_o");

  valid_low_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !v_o) else $error("v_o high in the cycle after reset");

endmodule

bind fdiv_fsqrt_unit fdiv_fsqrt_assert #(
  .WIDTH_P     (WIDTH_P),
  .TAG_WIDTH_P (TAG_WIDTH_P)
) assert_i (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .ready_o  (ready_o),
  .v_o      (v_o),
  .result_o (result_o),
  .flags_o  (flags_o),
  .rd_o     (rd_o),
  .op_o     (op_o),
  .yumi_i   (yumi_i)
);

// File: bench/tb_fdiv_fsqrt.sv
/*
 * Testbench for the fixed-point divide and square-root unit
 * Replays request vectors from a data file and checks every held result
 */
`timescale 1ns/1ps

module tb_fdiv_fsqrt;
  import fdiv_fsqrt_pkg::*;

  localparam int MAX_VEC_LP = 64;

  logic        clk_i;
  logic        reset_i;
  logic        v_i;
  logic [4:0]  rd_i;
  ds_op_e      op_i;
  ds_rm_e      rm_i;
  logic [15:0] a_i;
  logic [15:0] b_i;
  logic        ready_o;
  logic        v_o;
  logic [15:0] result_o;
  ds_flags_s   flags_o;
  logic [4:0]  rd_o;
  ds_op_e      op_o;
  logic        yumi_i;

  // Each vector holds op, rm, tag, a, b, expected result and expected flags
  logic [15:0] vec [MAX_VEC_LP][7];
  int          num_vec;
  logic        loaded;
  integer      seed;

  fdiv_fsqrt_unit dut_i (.*);

  always #5 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    fd = $fopen("bench/fdiv_fsqrt_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the test data file bench/fdiv_fsqrt_testdata.txt");
    end
    num_vec = 0;
    while (!$feof(fd) && num_vec < MAX_VEC_LP) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 0 && line.getc(0) != 8'h23) begin  // Skip lines starting with #
        n = $sscanf(line, "%h %h %h %h %h %h %h", vec[num_vec][0], vec[num_vec][1],
                    vec[num_vec][2], vec[num_vec][3], vec[num_vec][4], vec[num_vec][5],
                    vec[num_vec][6]);
        if (n == 7) begin
          num_vec++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_vector(input int idx);
    int delay;
    while (!ready_o) @(negedge clk_i);
    v_i  = 1'b1;
    op_i = ds_op_e'(vec[idx][0][0]);
    rm_i = ds_rm_e'(vec[idx][1][1:0]);
    rd_i = vec[idx][2][4:0];
    a_i  = vec[idx][3];
    b_i  = vec[idx][4];
    @(negedge clk_i);
    v_i = 1'b0;
    // Change the payload after acceptance so only the captured request reaches the outputs
    op_i = ds_op_e'(~vec[idx][0][0]);
    rd_i = ~vec[idx][2][4:0];
    a_i  = ~vec[idx][3];
    b_i  = ~vec[idx][4];

    while (!v_o) @(negedge clk_i);
    check(32'(result_o), 32'(vec[idx][5]), "result_o");
    check(32'(flags_o), 32'(vec[idx][6][2:0]), "flags_o");
    check(32'(rd_o), 32'(vec[idx][2][4:0]), "rd_o");
    check(32'(op_o), 32'(vec[idx][0][0]), "op_o");

    // Hold the result back for a few cycles before taking it
    delay = $unsigned($random(seed)) % 8;
    repeat (delay) begin
      @(negedge clk_i);
      check(32'(ready_o), 32'd0, "ready_o under back-pressure");
      check(32'(v_o), 32'd1, "v_o under back-pressure");
    end
    yumi_i = 1'b1;
    @(negedge clk_i);
    yumi_i = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    seed    = 18870;
    loaded  = 1'b0;
    clk_i   = 1'b0;
    reset_i = 1'b1;
    v_i     = 1'b0;
    rd_i    = '0;
    op_i    = DS_OP_DIV;
    rm_i    = DS_RM_RTZ;
    a_i     = '0;
    b_i     = '0;
    yumi_i  = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    for (int i = 0; i < num_vec; i++) begin
      run_vector(i);
    end
    if (num_vec == 0) begin
      abort_run("no test vectors were read from the data file");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // Reset takes 8 cycles and the longest request is well under 64 cycles with back-pressure
  initial begin
    wait (loaded);
    repeat (16 + num_vec * 64) @(posedge clk_i);
    abort_run($sformatf("timeout: %0d vectors did not finish within %0d cycles",
                        num_vec, 16 + num_vec * 64));
  end

endmodule

// File: files.f
logic/fdiv_fsqrt_pkg.sv
logic/ds_if.sv
logic/ds_issue.sv
logic/ds_iter_core.sv
logic/ds_writeback.sv
logic/fdiv_fsqrt_unit.sv
bench/fdiv_fsqrt_assert.sv
bench/tb_fdiv_fsqrt.sv

// File: Makefile
# Verilator build and run for the fixed-point divide and square-root unit
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_fdiv_fsqrt
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The testbench stops with $fatal on any failure, so the exit status carries the verdict
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/fdiv_fsqrt_testdata.txt
# op rm tag a b result flags, all hex; op 0 div 1 sqrt, rm 0 rtz 1 rup 2 rne
# Operands and results are Q8.8, flags are {dz, of, nx}
0 0 01 0100 0300 0055 1
0 1 02 0100 0300 0056 1
0 2 03 0200 0300 00ab 1
0 2 04 0003 0200 0002 1
0 2 05 0005 0200 0002 1
0 0 06 0003 0200 0001 1
0 1 07 0600 0200 0300 0
0 1 08 ffff 0100 ffff 0
0 0 09 c800 0080 ffff 2
0 1 0a 0100 0000 ffff 4
1 0 0b 0400 0000 0200 0
1 0 0c 0200 0000 016a 1
1 1 0d 0200 0000 016b 1
1 2 0e 0003 0000 001c 1
1 2 0f 0200 0000 016a 1
1 1 1f ffff 0000 1000 1
1 1 10 0240 1234 0180 0
